// ==== src.f ====
+incdir+logic
logic/dpDataPkg.sv
logic/dpCtrlPkg.sv
logic/addrSelect.sv
logic/regBank.sv
logic/alu.sv
logic/dpTop.sv
bench/dpTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the datapath testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f src.f --top-module dpTb -o dpSim

# A failing run exits nonzero, the log decides the outcome
obj_dir/dpSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

// ==== bench/dpTb.sv ====
/*
 * Datapath testbench
 * Direct, clear, indirect and ALU micro-operations checked against a reference model
 */
`timescale 1ns/1ps
`include "dpSettings.svh"

module dpTb;

	// ----------------------------------------------------------
	// Run length
	// ----------------------------------------------------------
	localparam int ResetCycles = 16;
	localparam int RegCount = `DP_REG_COUNT;
	localparam int IndirectRounds = 32;
	// Each pair loads r0 and r1 and then runs all eight ops
	localparam int CornerPairs = 8;
	localparam int RandomPairs = 30;
	localparam int TestCycles = ResetCycles + RegCount + 2 * RegCount + 6 * RegCount
		+ 4 * IndirectRounds + 10 * (CornerPairs + RandomPairs);
	// About three times the test length rounded up to a hundred
	localparam int TimeoutCycles = ((TestCycles * 10 / 3 + 99) / 100) * 100;

	// Expected ALU output
	typedef struct packed {
		dpDataPkg::word_t     result;
		dpDataPkg::aluFlags_t flags;
	} aluOut_t;

	logic                 clock50;
	logic                 rstN;
	dpCtrlPkg::microOp_t  uop;
	dpDataPkg::word_t     wrData;
	dpDataPkg::word_t     busA;
	dpDataPkg::word_t     busB;
	dpDataPkg::word_t     irWord;
	dpDataPkg::word_t     aluResult;
	dpDataPkg::aluFlags_t flags;

	int seed;
	int cycleCount = 0;
	int failCount = 0;

	// Reference model
	dpDataPkg::word_t    model [RegCount];
	dpDataPkg::word_t    irModel;
	dpCtrlPkg::regAddr_t modelA;
	dpCtrlPkg::regAddr_t modelB;
	dpCtrlPkg::regAddr_t modelC;
	dpDataPkg::word_t    expA;
	dpDataPkg::word_t    expB;
	aluOut_t             expAlu;

	dpTop i_dpTop (
		.clock50   (clock50),
		.rstN      (rstN),
		.uop       (uop),
		.wrData    (wrData),
		.busA      (busA),
		.busB      (busB),
		.irWord    (irWord),
		.aluResult (aluResult),
		.flags     (flags)
	);

	// 8 ns period
	initial begin
		clock50 = 1'b0;
		forever #4 clock50 = ~clock50;
	end

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------
	function automatic aluOut_t expectAlu(dpDataPkg::aluOp_t op, dpDataPkg::word_t a,
		dpDataPkg::word_t b);
		aluOut_t out;
		longint trueValue;
		logic [`DP_WORD_W:0] wide;
		out = '0;
		trueValue = 0;
		wide = '0;
		case (op)
			dpDataPkg::ADD: begin
				wide = {1'b0, a} + {1'b0, b};
				out.result = wide[`DP_WORD_W-1:0];
				out.flags.carry = wide[`DP_WORD_W];
				trueValue = longint'($signed(a)) + longint'($signed(b));
				// Signed overflow when the true sum does not fit a word
				out.flags.overflow = (trueValue != longint'($signed(out.result)));
			end
			dpDataPkg::SUB: begin
				out.result = a - b;
				// Carry out of A + ~B + 1 is set when no borrow occurs
				out.flags.carry = (a >= b);
				trueValue = longint'($signed(a)) - longint'($signed(b));
				out.flags.overflow = (trueValue != longint'($signed(out.result)));
			end
			dpDataPkg::AND:   out.result = a & b;
			dpDataPkg::OR:    out.result = a | b;
			dpDataPkg::XOR:   out.result = a ^ b;
			dpDataPkg::PASSA: out.result = a;
			dpDataPkg::PASSB: out.result = b;
			dpDataPkg::NOTA:  out.result = ~a;
		endcase
		out.flags.zero = (out.result == '0);
		out.flags.negative = out.result[`DP_WORD_W-1];
		return out;
	endfunction

	// Address decode and expected outputs from the model state before the edge
	always_comb begin
		irModel = model[dpCtrlPkg::IR];
		modelA = uop.aFromIr ? irModel[`DP_RS1_LSB +: `DP_ADDR_W] : uop.aAddr;
		modelB = uop.bFromIr ? irModel[`DP_RS2_LSB +: `DP_ADDR_W] : uop.bAddr;
		modelC = uop.cFromIr ? irModel[`DP_RD_LSB +: `DP_ADDR_W] : uop.cAddr;
		expA = model[modelA];
		expB = model[modelB];
		expAlu = expectAlu(uop.aluOp, expA, expB);
	end

	always @(posedge clock50 or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < RegCount; i++) begin
				model[i] <= '0;
			end
		end else begin
			// Clear wins over a write to the same register
			if (uop.wrEn && !(uop.clrEn && uop.clrAddr == modelC)) begin
				model[modelC] <= wrData;
			end
			if (uop.clrEn) begin
				model[uop.clrAddr] <= '0;
			end
		end
	end

	// ----------------------------------------------------------
	// Failure handling
	// ----------------------------------------------------------
	task automatic stopWithFailure(string why);
		if (why != "") begin
			$display("%s", why);
		end
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(string name, dpDataPkg::word_t got, dpDataPkg::word_t want);
		failCount++;
		$display("** Error: %s is %h, expected %h at %0t", name, got, want, $time);
		stopWithFailure("");
	endtask

	// ----------------------------------------------------------
	// Output checks
	// ----------------------------------------------------------
	busAMatch: assert property (@(posedge clock50) disable iff (!rstN) busA == expA)
		else reportMismatch("busA", $sampled(busA), $sampled(expA));

	busBMatch: assert property (@(posedge clock50) disable iff (!rstN) busB == expB)
		else reportMismatch("busB", $sampled(busB), $sampled(expB));

	irWordMatch: assert property (@(posedge clock50) disable iff (!rstN) irWord == irModel)
		else reportMismatch("irWord", $sampled(irWord), $sampled(irModel));

	aluResultMatch: assert property (@(posedge clock50) disable iff (!rstN)
		aluResult == expAlu.result)
		else reportMismatch("aluResult", $sampled(aluResult), $sampled(expAlu.result));

	flagsMatch: assert property (@(posedge clock50) disable iff (!rstN)
		flags == expAlu.flags)
		else reportMismatch("flags", dpDataPkg::word_t'($sampled(flags)),
			dpDataPkg::word_t'($sampled(expAlu.flags)));

	// Hang guard
	always @(posedge clock50) begin
		cycleCount++;
		if (cycleCount >= TimeoutCycles) begin
			stopWithFailure($sformatf("Timeout: run did not finish within %0d cycles",
				TimeoutCycles));
		end
	end

	// ----------------------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------------------
	function automatic dpDataPkg::word_t randWord();
		return dpDataPkg::word_t'($random(seed));
	endfunction

	function automatic dpDataPkg::aluOp_t randOp();
		logic [2:0] code;
		code = 3'($random(seed));
		return dpDataPkg::aluOp_t'(code);
	endfunction

	// One micro-operation per cycle applied on the falling edge
	task automatic runCycle(dpCtrlPkg::microOp_t u, dpDataPkg::word_t d);
		@(negedge clock50);
		uop = u;
		wrData = d;
	endtask

	task automatic driveOp(dpCtrlPkg::regAddr_t a, dpCtrlPkg::regAddr_t b,
		dpDataPkg::aluOp_t op, logic wr, dpCtrlPkg::regAddr_t c, logic clr,
		dpCtrlPkg::regAddr_t clrA, dpDataPkg::word_t d);
		dpCtrlPkg::microOp_t u;
		u = '0;
		u.aAddr = a;
		u.bAddr = b;
		u.aluOp = op;
		u.wrEn = wr;
		u.cAddr = c;
		u.clrEn = clr;
		u.clrAddr = clrA;
		runCycle(u, d);
	endtask

	task automatic readRegs(dpCtrlPkg::regAddr_t a, dpCtrlPkg::regAddr_t b,
		dpDataPkg::aluOp_t op);
		driveOp(a, b, op, 1'b0, dpCtrlPkg::R0, 1'b0, dpCtrlPkg::R0, randWord());
	endtask

	task automatic writeReg(dpCtrlPkg::regAddr_t c, dpDataPkg::word_t d);
		driveOp(c, c, dpDataPkg::ADD, 1'b1, c, 1'b0, dpCtrlPkg::R0, d);
	endtask

	// All three addresses from the IR fields
	task automatic indirectOp(logic wr, dpDataPkg::word_t d, dpDataPkg::aluOp_t op);
		dpCtrlPkg::microOp_t u;
		u = '0;
		u.aFromIr = 1'b1;
		u.bFromIr = 1'b1;
		u.cFromIr = 1'b1;
		u.wrEn = wr;
		u.aluOp = op;
		runCycle(u, d);
	endtask

	// Same target, clear alone and different targets, each read back on the next op
	task automatic clearCases(dpCtrlPkg::regAddr_t r);
		dpCtrlPkg::regAddr_t other;
		other = r + 3'd1;
		writeReg(r, randWord());
		driveOp(r, other, dpDataPkg::ADD, 1'b1, r, 1'b1, r, randWord());
		driveOp(r, other, dpDataPkg::XOR, 1'b0, r, 1'b1, other, randWord());
		writeReg(r, randWord());
		driveOp(r, other, dpDataPkg::OR, 1'b1, other, 1'b1, r, randWord());
		driveOp(r, other, dpDataPkg::SUB, 1'b0, r, 1'b0, r, randWord());
	endtask

	task automatic indirectRound();
		dpDataPkg::word_t irVal;
		irVal = randWord();
		writeReg(dpCtrlPkg::IR, irVal);
		indirectOp(1'b0, randWord(), randOp());
		indirectOp(1'b1, randWord(), randOp());
		// rd and rs1 read back directly
		readRegs(irVal[`DP_RD_LSB +: `DP_ADDR_W], irVal[`DP_RS1_LSB +: `DP_ADDR_W],
			dpDataPkg::ADD);
	endtask

	task automatic aluPair(dpDataPkg::word_t a, dpDataPkg::word_t b);
		writeReg(dpCtrlPkg::R0, a);
		writeReg(dpCtrlPkg::R1, b);
		for (int i = 0; i < 8; i++) begin
			readRegs(dpCtrlPkg::R0, dpCtrlPkg::R1, dpDataPkg::aluOp_t'(3'(i)));
		end
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		dpDataPkg::word_t data;
		seed = 32'h5f5a_c2ca;
		rstN = 1'b0;
		uop = '0;
		wrData = '0;
		repeat (ResetCycles) @(posedge clock50);
		@(negedge clock50);
		rstN = 1'b1;

		// Reset values on every address
		for (int i = 0; i < RegCount; i++) begin
			readRegs(dpCtrlPkg::regAddr_t'(i), dpCtrlPkg::regAddr_t'(RegCount - 1 - i),
				dpDataPkg::aluOp_t'(3'(i)));
		end

		// Direct write and read back next cycle
		for (int i = 0; i < RegCount; i++) begin
			data = randWord();
			writeReg(dpCtrlPkg::regAddr_t'(i), data);
			readRegs(dpCtrlPkg::regAddr_t'(i), dpCtrlPkg::regAddr_t'(i), dpDataPkg::PASSA);
		end

		for (int i = 0; i < RegCount; i++) begin
			clearCases(dpCtrlPkg::regAddr_t'(i));
		end

		repeat (IndirectRounds) indirectRound();

		// Corner operands
		aluPair(32'h0000_0000, 32'h0000_0000);
		aluPair(32'hffff_ffff, 32'hffff_ffff);
		aluPair(32'h8000_0000, 32'h8000_0000);
		aluPair(32'h7fff_ffff, 32'h0000_0001);
		aluPair(32'hffff_ffff, 32'h0000_0001);
		aluPair(32'h8000_0000, 32'h0000_0001);
		aluPair(32'h0000_0000, 32'h0000_0001);
		aluPair(32'h1234_5678, 32'h1234_5678);

		repeat (RandomPairs) aluPair(randWord(), randWord());

		// Last operation still gets its check
		runCycle('0, '0);
		@(posedge clock50);
		#1;
		if (failCount == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			stopWithFailure("Run ended with failed checks");
		end
	end

endmodule

// ==== logic/dpTop.sv ====
/*
 * Datapath top level
 * Address selection, register bank and ALU
 */
`timescale 1ns/1ps

module dpTop (
	input  logic                 clock50,
	input  logic                 rstN,
	input  dpCtrlPkg::microOp_t  uop,
	input  dpDataPkg::word_t     wrData,
	output dpDataPkg::word_t     busA,
	output dpDataPkg::word_t     busB,
	output dpDataPkg::word_t     irWord,
	output dpDataPkg::word_t     aluResult,
	output dpDataPkg::aluFlags_t flags
);

	// Resolved register addresses
	dpCtrlPkg::regAddr_t aAddr;
	dpCtrlPkg::regAddr_t bAddr;
	dpCtrlPkg::regAddr_t cAddr;

	// ----------------------------------------------------------
	// Address selection
	// ----------------------------------------------------------
	// Indirect addresses use the IR as currently stored
	addrSelect i_addrSelect (
		.uop    (uop),
		.irWord (irWord),
		.aAddr  (aAddr),
		.bAddr  (bAddr),
		.cAddr  (cAddr)
	);

	// ----------------------------------------------------------
	// Register bank
	// ----------------------------------------------------------
	regBank i_regBank (
		.clock50 (clock50),
		.rstN    (rstN),
		.aAddr   (aAddr),
		.bAddr   (bAddr),
		.cAddr   (cAddr),
		.wrEn    (uop.wrEn),
		.clrEn   (uop.clrEn),
		.clrAddr (uop.clrAddr),
		.wrData  (wrData),
		.busA    (busA),
		.busB    (busB),
		.irWord  (irWord)
	);

	// ----------------------------------------------------------
	// ALU
	// ----------------------------------------------------------
	// Operates on the two read buses
	alu i_alu (
		.a      (busA),
		.b      (busB),
		.op     (uop.aluOp),
		.result (aluResult),
		.flags  (flags)
	);

endmodule

// ==== logic/alu.sv ====
/*
 * Combinational ALU
 * Eight operations on buses A and B, with overflow, carry, negative and zero
 */
`timescale 1ns/1ps
`include "dpSettings.svh"

module alu (
	input  dpDataPkg::word_t     a,
	input  dpDataPkg::word_t     b,
	input  dpDataPkg::aluOp_t    op,
	output dpDataPkg::word_t     result,
	output dpDataPkg::aluFlags_t flags
);

	// Sign bit position
	localparam int MsB = `DP_WORD_W - 1;

	// Subtract is A + ~B + 1 through the same adder
	logic                 isSub;
	logic                 isArith;
	dpDataPkg::word_t     bOperand;
	logic [`DP_WORD_W:0]  sum;

	// ----------------------------------------------------------
	// Shared adder
	// ----------------------------------------------------------
	always_comb begin
		isSub = (op == dpDataPkg::SUB);
		isArith = (op == dpDataPkg::ADD) || isSub;
		bOperand = isSub ? ~b : b;
		// Extra top bit holds the carry out
		sum = {1'b0, a} + {1'b0, bOperand} + {{`DP_WORD_W{1'b0}}, isSub};
	end

	// ----------------------------------------------------------
	// Result select
	// ----------------------------------------------------------
	always_comb begin
		result = '0;
		case (op)
			dpDataPkg::ADD:   result = sum[MsB:0];
			dpDataPkg::SUB:   result = sum[MsB:0];
			dpDataPkg::AND:   result = a & b;
			dpDataPkg::OR:    result = a | b;
			dpDataPkg::XOR:   result = a ^ b;
			dpDataPkg::PASSA: result = a;
			dpDataPkg::PASSB: result = b;
			// All ones out of reset
			dpDataPkg::NOTA:  result = ~a;
		endcase
	end

	// ----------------------------------------------------------
	// Flags
	// ----------------------------------------------------------
	always_comb begin
		// Follow the result for every op
		flags.zero = (result == '0);
		flags.negative = result[MsB];
		// Carry out of the adder, no borrow inversion on SUB
		flags.carry = isArith & sum[`DP_WORD_W];
		// Same-sign operands giving an opposite-sign sum
		flags.overflow = isArith & (a[MsB] == bOperand[MsB]) & (sum[MsB] != a[MsB]);
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	// Op code must be one of the eight defined encodings
	always_comb begin
		assert final (!$isunknown(op) && (op inside {dpDataPkg::ADD, dpDataPkg::SUB,
			dpDataPkg::AND, dpDataPkg::OR, dpDataPkg::XOR, dpDataPkg::PASSA,
			dpDataPkg::PASSB, dpDataPkg::NOTA}))
			else $error("alu: illegal operation code");
	end

endmodule

// ==== logic/regBank.sv ====
/*
 * Eight-register bank
 * One write port, one clear port and two read buses
 */
`timescale 1ns/1ps
`include "dpSettings.svh"

module regBank (
	input  logic                clock50,
	input  logic                rstN,
	input  dpCtrlPkg::regAddr_t aAddr,
	input  dpCtrlPkg::regAddr_t bAddr,
	input  dpCtrlPkg::regAddr_t cAddr,
	input  logic                wrEn,
	input  logic                clrEn,
	input  dpCtrlPkg::regAddr_t clrAddr,
	input  dpDataPkg::word_t    wrData,
	output dpDataPkg::word_t    busA,
	output dpDataPkg::word_t    busB,
	output dpDataPkg::word_t    irWord
);

	// r0..r3, rs, pc, ir, temp0
	dpDataPkg::word_t regs [`DP_REG_COUNT];

	// One-hot enables, one bit per register
	logic [`DP_REG_COUNT-1:0] wrSel;
	logic [`DP_REG_COUNT-1:0] clrSel;

	// ----------------------------------------------------------
	// Enable decode
	// ----------------------------------------------------------
	always_comb begin
		wrSel = '0;
		clrSel = '0;
		wrSel[cAddr] = wrEn;
		clrSel[clrAddr] = clrEn;
	end

	// ----------------------------------------------------------
	// Register update
	// ----------------------------------------------------------
	always_ff @(posedge clock50 or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `DP_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `DP_REG_COUNT; i++) begin
				// Clear first, write only when not cleared
				if (clrSel[i]) begin
					regs[i] <= '0;
				end else if (wrSel[i]) begin
					regs[i] <= wrData;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// Read side
	// ----------------------------------------------------------
	// Buses follow the stored state in the same cycle
	assign busA = regs[aAddr];
	assign busB = regs[bAddr];

	// IR goes straight out for field decode
	assign irWord = regs[dpCtrlPkg::IR];

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	// Cleared register reads zero one cycle later, whatever the write port did
	clearTakes: assert property (
		@(posedge clock50) disable iff (!rstN)
		clrEn |=> (regs[$past(clrAddr)] == '0)
	) else $error("regBank: register not zero after clear");

endmodule

// ==== logic/addrSelect.sv ====
/*
 * Register address selection
 * Picks the A, B and C addresses from microcode or IR fields
 */
`timescale 1ns/1ps
`include "dpSettings.svh"

module addrSelect (
	input  dpCtrlPkg::microOp_t uop,
	input  dpDataPkg::word_t    irWord,
	output dpCtrlPkg::regAddr_t aAddr,
	output dpCtrlPkg::regAddr_t bAddr,
	output dpCtrlPkg::regAddr_t cAddr
);

	// ----------------------------------------------------------
	// IR fields
	// ----------------------------------------------------------
	// Only the low address bits of each 5-bit field
	dpCtrlPkg::regAddr_t rs1Field;
	dpCtrlPkg::regAddr_t rs2Field;
	dpCtrlPkg::regAddr_t rdField;

	assign rs1Field = irWord[`DP_RS1_LSB +: `DP_ADDR_W];
	assign rs2Field = irWord[`DP_RS2_LSB +: `DP_ADDR_W];
	assign rdField  = irWord[`DP_RD_LSB +: `DP_ADDR_W];

	// ----------------------------------------------------------
	// Address muxes
	// ----------------------------------------------------------
	// Bus A
	assign aAddr = uop.aFromIr ? rs1Field : uop.aAddr;
	// Bus B
	assign bAddr = uop.bFromIr ? rs2Field : uop.bAddr;
	// Write port
	assign cAddr = uop.cFromIr ? rdField : uop.cAddr;

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	// Select bits must be driven from time zero on
	always_comb begin
		assert final (!$isunknown({uop.aFromIr, uop.bFromIr, uop.cFromIr}))
			else $error("addrSelect: unknown address select bit");
	end

endmodule

// ==== logic/dpCtrlPkg.sv ====
/*
 * Control-side types of the datapath
 * Register addresses, register names and the micro-operation word
 */
`include "dpSettings.svh"

package dpCtrlPkg;

	// Register address, one of eight
	typedef logic [`DP_ADDR_W-1:0] regAddr_t;

	// ----------------------------------------------------------
	// Register names
	// ----------------------------------------------------------
	localparam regAddr_t R0    = 3'd0;
	localparam regAddr_t R1    = 3'd1;
	localparam regAddr_t R2    = 3'd2;
	localparam regAddr_t R3    = 3'd3;
	localparam regAddr_t RS    = 3'd4;
	localparam regAddr_t PC    = 3'd5;
	localparam regAddr_t IR    = 3'd6;
	localparam regAddr_t TEMP0 = 3'd7;

	// ----------------------------------------------------------
	// Micro-operation, one per cycle
	// ----------------------------------------------------------
	typedef struct packed {
		// Bus A source, rs1 field when set
		logic                 aFromIr;
		regAddr_t             aAddr;
		// Bus B source, rs2 field when set
		logic                 bFromIr;
		regAddr_t             bAddr;
		// Write target, rd field when set
		logic                 cFromIr;
		regAddr_t             cAddr;
		logic                 wrEn;
		// Clear port, beats a write to the same register
		logic                 clrEn;
		regAddr_t             clrAddr;
		dpDataPkg::aluOp_t    aluOp;
	} microOp_t;

endpackage

// ==== logic/dpDataPkg.sv ====
/*
 * Data-side types of the datapath
 * Bus words, ALU operation codes and ALU flags
 */
`include "dpSettings.svh"

package dpDataPkg;

	// Word carried on every bus
	typedef logic [`DP_WORD_W-1:0] word_t;

	// ----------------------------------------------------------
	// ALU operations
	// ----------------------------------------------------------
	// Full 3-bit code space is used
	typedef enum logic [2:0] {
		ADD   = 3'd0,
		SUB   = 3'd1,
		AND   = 3'd2,
		OR    = 3'd3,
		XOR   = 3'd4,
		PASSA = 3'd5,
		PASSB = 3'd6,
		NOTA  = 3'd7
	} aluOp_t;

	// Flags, active high
	typedef struct packed {
		logic overflow;
		logic carry;
		logic negative;
		logic zero;
	} aluFlags_t;

endpackage

// ==== logic/dpSettings.svh ====
/*
 * Datapath settings
 * Word width, register file size and IR field positions
 */
`ifndef DP_SETTINGS_SVH
`define DP_SETTINGS_SVH

// ----------------------------------------------------------
// Data word
// ----------------------------------------------------------
`define DP_WORD_W 32

// ----------------------------------------------------------
// Register file
// ----------------------------------------------------------
`define DP_REG_COUNT 8
// Enough bits to name every register
`define DP_ADDR_W 3

// ----------------------------------------------------------
// Instruction register fields, lowest bit of each
// ----------------------------------------------------------
// Source 1 feeds bus A
`define DP_RS1_LSB 14
// Source 2 feeds bus B
`define DP_RS2_LSB 0
// Destination for port C
`define DP_RD_LSB 25

`endif
